//--- design/exe_pkg.sv
// Widths, default parameters, opcode enum, tag, operation, multiply and result structs
package exe_pkg;

	parameter int XLEN = 32;
	parameter int REG_AW = 5;

	// Stage count must divide XLEN
	parameter int DEF_MUL_STAGES = 4;
	parameter int DEF_CREDITS = 4;

	typedef enum logic [3:0] {
		OP_ADD = 4'd0,
		OP_SUB = 4'd1,
		OP_AND = 4'd2,
		OP_OR  = 4'd3,
		OP_XOR = 4'd4,
		OP_SLL = 4'd5,
		OP_SRL = 4'd6,
		OP_SLT = 4'd7,
		OP_MUL = 4'd8
	} exe_op_e;

	// Destination and PC follow every operation down both paths
	typedef struct packed {
		logic [REG_AW-1:0] rd;
		logic [XLEN-1:0]   pc;
	} exe_tag_t;

	typedef struct packed {
		exe_op_e         op;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		exe_tag_t        tag;
	} exe_op_t;

	typedef struct packed {
		logic            valid;
		exe_tag_t        tag;
		logic [XLEN-1:0] acc;
		logic [XLEN-1:0] mcand;
		logic [XLEN-1:0] mplier;
	} mul_pipe_t;

	typedef struct packed {
		logic [XLEN-1:0] value;
		exe_tag_t        tag;
		logic            we;
	} exe_result_t;

endpackage

//--- design/int_issue.sv
`timescale 1ns/100ps
// Issue unit with result credits, write-back slot check and dispatch to ALU and multiplier
module int_issue #(
	parameter int MUL_STAGES = exe_pkg::DEF_MUL_STAGES,
	parameter int CREDITS = exe_pkg::DEF_CREDITS
) (
	input  logic                clk_i,
	input  logic                reset_i,
	input  logic                op_valid_i,
	input  exe_pkg::exe_op_t    op_i,
	input  logic                credit_return_i,
	output logic                op_ready_o,
	output logic                alu_valid_o,
	output exe_pkg::exe_op_t    alu_op_o,
	output exe_pkg::mul_pipe_t  mul_o
);

	localparam int CNT_W = $clog2(CREDITS + 1);

	logic [CNT_W-1:0]      credit_cnt;
	logic [MUL_STAGES-2:0] mul_hist;
	logic                  mul_valid_q;
	logic                  is_mul;
	logic                  slot_clash;
	logic                  accept;

	if (MUL_STAGES < 2) begin : g_stage_check
		$error("int_issue needs at least two multiply stages");
	end

	assign is_mul = (op_i.op == exe_pkg::OP_MUL);

	// ALU op would hit write-back together with an older multiply
	assign slot_clash = !is_mul && mul_hist[MUL_STAGES-2];
	assign op_ready_o = (credit_cnt != '0) && !slot_clash;
	assign accept = op_valid_i && op_ready_o;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			credit_cnt <= CNT_W'(CREDITS);
		end else if (accept && !credit_return_i) begin
			credit_cnt <= credit_cnt - 1'b1;
		end else if (!accept && credit_return_i) begin
			credit_cnt <= credit_cnt + 1'b1;
		end
	end

	// Bit k set when a multiply was accepted k+1 cycles ago
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			mul_hist <= '0;
		end else begin
			mul_hist[0] <= accept && is_mul;
			for (int k = 1; k < MUL_STAGES - 1; k++) begin
				mul_hist[k] <= mul_hist[k-1];
			end
		end
	end

	always_ff @(posedge clk_i) begin
		alu_op_o <= op_i;
		if (reset_i) begin
			alu_valid_o <= 1'b0;
			mul_valid_q <= 1'b0;
		end else begin
			alu_valid_o <= accept && !is_mul;
			mul_valid_q <= accept && is_mul;
		end
	end

	// Multiply enters the chain with an empty accumulator
	assign mul_o.valid = mul_valid_q;
	assign mul_o.tag = alu_op_o.tag;
	assign mul_o.acc = '0;
	assign mul_o.mcand = alu_op_o.a;
	assign mul_o.mplier = alu_op_o.b;

	a_credit_max: assert property (@(posedge clk_i) disable iff (reset_i)
		credit_cnt <= CNT_W'(CREDITS));

	// Consumer may only return what it was given
	a_no_spare_return: assert property (@(posedge clk_i) disable iff (reset_i)
		credit_return_i |-> credit_cnt != CNT_W'(CREDITS));

endmodule

//--- design/int_alu.sv
`timescale 1ns/100ps
// Registered single-cycle integer ALU
module int_alu (
	input  logic                 clk_i,
	input  logic                 reset_i,
	input  logic                 alu_valid_i,
	input  exe_pkg::exe_op_t     alu_op_i,
	output logic                 alu_valid_o,
	output exe_pkg::exe_result_t alu_result_o
);

	localparam int SH_W = $clog2(exe_pkg::XLEN);

	logic [exe_pkg::XLEN-1:0] op_a;
	logic [exe_pkg::XLEN-1:0] op_b;
	logic [exe_pkg::XLEN-1:0] value;
	logic [SH_W-1:0]          shamt;

	assign op_a = alu_op_i.a;
	assign op_b = alu_op_i.b;
	assign shamt = op_b[SH_W-1:0];

	always_comb begin
		case (alu_op_i.op)
			exe_pkg::OP_ADD: value = op_a + op_b;
			exe_pkg::OP_SUB: value = op_a - op_b;
			exe_pkg::OP_AND: value = op_a & op_b;
			exe_pkg::OP_OR:  value = op_a | op_b;
			exe_pkg::OP_XOR: value = op_a ^ op_b;
			exe_pkg::OP_SLL: value = op_a << shamt;
			exe_pkg::OP_SRL: value = op_a >> shamt;
			// Signed compare
			exe_pkg::OP_SLT: value = {{(exe_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			default:         value = '0;
		endcase
	end

	always_ff @(posedge clk_i) begin
		alu_result_o.value <= value;
		alu_result_o.tag <= alu_op_i.tag;
		alu_result_o.we <= 1'b1;
		if (reset_i) begin
			alu_valid_o <= 1'b0;
		end else begin
			alu_valid_o <= alu_valid_i;
		end
	end

endmodule

//--- design/mul_stage.sv
`timescale 1ns/100ps
// One multiply pipeline stage adding the partial products of its multiplier slice
module mul_stage #(
	parameter int MUL_STAGES = exe_pkg::DEF_MUL_STAGES
) (
	input  logic               clk_i,
	input  logic               reset_i,
	input  exe_pkg::mul_pipe_t stage_i,
	output exe_pkg::mul_pipe_t stage_o
);

	localparam int SLICE = exe_pkg::XLEN / MUL_STAGES;

	logic [exe_pkg::XLEN-1:0] acc_next;

	if (exe_pkg::XLEN % MUL_STAGES != 0) begin : g_split_check
		$error("mul_stage needs MUL_STAGES to divide XLEN");
	end

	// Low bits of the remaining multiplier belong to this stage
	always_comb begin
		acc_next = stage_i.acc;
		for (int i = 0; i < SLICE; i++) begin
			if (stage_i.mplier[i]) begin
				acc_next = acc_next + (stage_i.mcand << i);
			end
		end
	end

	always_ff @(posedge clk_i) begin
		stage_o.tag <= stage_i.tag;
		stage_o.acc <= acc_next;
		stage_o.mcand <= stage_i.mcand << SLICE;
		stage_o.mplier <= stage_i.mplier >> SLICE;
		if (reset_i) begin
			stage_o.valid <= 1'b0;
		end else begin
			stage_o.valid <= stage_i.valid;
		end
	end

endmodule

//--- design/exe_writeback.sv
`timescale 1ns/100ps
// Write-back merge of ALU and multiply results with register zero suppression
module exe_writeback (
	input  logic                 clk_i,
	input  logic                 reset_i,
	input  logic                 alu_valid_i,
	input  exe_pkg::exe_result_t alu_result_i,
	input  exe_pkg::mul_pipe_t   mul_i,
	output logic                 result_valid_o,
	output exe_pkg::exe_result_t result_o
);

	exe_pkg::exe_result_t sel;

	always_comb begin
		if (alu_valid_i) begin
			sel = alu_result_i;
		end else begin
			sel.value = mul_i.acc;
			sel.tag = mul_i.tag;
			sel.we = 1'b1;
		end
		// x0 is hardwired
		if (sel.tag.rd == '0) begin
			sel.we = 1'b0;
		end
	end

	always_ff @(posedge clk_i) begin
		result_o <= sel;
		if (reset_i) begin
			result_valid_o <= 1'b0;
		end else begin
			result_valid_o <= alu_valid_i || mul_i.valid;
		end
	end

	// Issue keeps the two paths out of the same write-back slot
	a_one_source: assert property (@(posedge clk_i) disable iff (reset_i)
		!(alu_valid_i && mul_i.valid));

endmodule

//--- design/exe_backend.sv
`timescale 1ns/100ps
// Integer execute back-end top with issue, ALU, multiply chain and write-back
module exe_backend #(
	parameter int MUL_STAGES = exe_pkg::DEF_MUL_STAGES,
	parameter int CREDITS = exe_pkg::DEF_CREDITS
) (
	input  logic                 clk_i,
	input  logic                 reset_i,
	input  logic                 op_valid_i,
	input  exe_pkg::exe_op_t     op_i,
	output logic                 op_ready_o,
	output logic                 result_valid_o,
	output exe_pkg::exe_result_t result_o,
	input  logic                 credit_return_i
);

	logic                 alu_in_valid;
	exe_pkg::exe_op_t     alu_op;
	logic                 alu_out_valid;
	exe_pkg::exe_result_t alu_result;

	// Entry 0 from issue, last entry into write-back
	exe_pkg::mul_pipe_t mul_chain [0:MUL_STAGES];

	int_issue #(
		.MUL_STAGES (MUL_STAGES),
		.CREDITS    (CREDITS)
	) u_issue (
		.clk_i           (clk_i),
		.reset_i         (reset_i),
		.op_valid_i      (op_valid_i),
		.op_i            (op_i),
		.credit_return_i (credit_return_i),
		.op_ready_o      (op_ready_o),
		.alu_valid_o     (alu_in_valid),
		.alu_op_o        (alu_op),
		.mul_o           (mul_chain[0])
	);

	int_alu u_alu (
		.clk_i        (clk_i),
		.reset_i      (reset_i),
		.alu_valid_i  (alu_in_valid),
		.alu_op_i     (alu_op),
		.alu_valid_o  (alu_out_valid),
		.alu_result_o (alu_result)
	);

	for (genvar k = 0; k < MUL_STAGES; k++) begin : g_mul
		mul_stage #(
			.MUL_STAGES (MUL_STAGES)
		) u_stage (
			.clk_i   (clk_i),
			.reset_i (reset_i),
			.stage_i (mul_chain[k]),
			.stage_o (mul_chain[k+1])
		);
	end

	exe_writeback u_writeback (
		.clk_i          (clk_i),
		.reset_i        (reset_i),
		.alu_valid_i    (alu_out_valid),
		.alu_result_i   (alu_result),
		.mul_i          (mul_chain[MUL_STAGES]),
		.result_valid_o (result_valid_o),
		.result_o       (result_o)
	);

endmodule

//--- dv/exe_backend_tb.sv
`timescale 1ns/100ps
// Execute back-end testbench with clock, reset, LFSR, reference model and directed tests
module exe_backend_tb;

	localparam int TIMEOUT = 200;
	localparam int ALU_LAT = 2;
	localparam int MUL_LAT = exe_pkg::DEF_MUL_STAGES + 1;

	logic                     clk;
	logic                     reset = 1'b1;
	logic                     op_valid = 1'b0;
	exe_pkg::exe_op_t         op = '0;
	logic                     op_ready;
	logic                     result_valid;
	exe_pkg::exe_result_t     result;
	logic                     credit_return = 1'b0;

	logic [31:0]              lfsr = 32'h17a50cd1;
	logic [exe_pkg::XLEN-1:0] next_pc = 32'h0000_1000;
	logic [exe_pkg::XLEN-1:0] rx_pc;
	int                       cycle = 0;
	int                       owed = 0;
	bit                       hold_credits = 1'b0;
	bit                       failed = 1'b0;

	// Outstanding results keyed by PC as ALU results can overtake multiplies
	exe_pkg::exe_result_t exp_res [logic [exe_pkg::XLEN-1:0]];
	int                   exp_cycle [logic [exe_pkg::XLEN-1:0]];

	exe_backend u_dut (
		.clk_i           (clk),
		.reset_i         (reset),
		.op_valid_i      (op_valid),
		.op_i            (op),
		.op_ready_o      (op_ready),
		.result_valid_o  (result_valid),
		.result_o        (result),
		.credit_return_i (credit_return)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	task automatic report_mismatch(input string msg);
		failed = 1'b1;
		$display("MISMATCH at %0t: %s", $time, msg);
		$display("TEST FAILED");
		$fatal(1, "stopping at first error");
	endtask

	task automatic report_error(input string msg);
		failed = 1'b1;
		$display("ERROR at %0t: %s", $time, msg);
		$display("TEST FAILED");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_result(input exe_pkg::exe_result_t got, input exe_pkg::exe_result_t exp);
		if (got !== exp) begin
			report_mismatch($sformatf("pc %h rd %0d value %h we %b, expected rd %0d value %h we %b",
				got.tag.pc, got.tag.rd, got.value, got.we, exp.tag.rd, exp.value, exp.we));
		end
	endtask

	task automatic check_ready(input bit got, input bit exp, input string what);
		if (got !== exp) begin
			report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
		end
	endtask

	// Fibonacci LFSR with taps 32 22 2 1 stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic logic [31:0] ref_value(input exe_pkg::exe_op_e fn, input logic [31:0] a,
			input logic [31:0] b);
		case (fn)
			exe_pkg::OP_ADD: return a + b;
			exe_pkg::OP_SUB: return a - b;
			exe_pkg::OP_AND: return a & b;
			exe_pkg::OP_OR:  return a | b;
			exe_pkg::OP_XOR: return a ^ b;
			exe_pkg::OP_SLL: return a << b[4:0];
			exe_pkg::OP_SRL: return a >> b[4:0];
			exe_pkg::OP_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			exe_pkg::OP_MUL: return a * b;
			default:         return '0;
		endcase
	endfunction

	// Checks every result by its PC and returns its credit unless credits are held
	always @(negedge clk) begin
		credit_return = 1'b0;
		if (!reset && result_valid) begin
			rx_pc = result.tag.pc;
			if (!exp_res.exists(rx_pc)) begin
				report_error($sformatf("result arrived for PC %h that was never accepted", rx_pc));
			end else begin
				check_result(result, exp_res[rx_pc]);
				if (cycle != exp_cycle[rx_pc]) begin
					report_mismatch($sformatf("pc %h arrived in cycle %0d, expected %0d",
						rx_pc, cycle, exp_cycle[rx_pc]));
				end
				exp_res.delete(rx_pc);
				exp_cycle.delete(rx_pc);
				owed++;
			end
		end
		if (!hold_credits && owed > 0) begin
			credit_return = 1'b1;
			owed--;
		end
	end

	// Called at a falling edge and returns at the falling edge after the accepting edge
	task automatic issue_op(input exe_pkg::exe_op_e fn, input logic [31:0] a, input logic [31:0] b,
			input logic [4:0] rd, input bit refused);
		exe_pkg::exe_op_t     o;
		exe_pkg::exe_result_t e;
		int                   waited;
		o.op = fn;
		o.a = a;
		o.b = b;
		o.tag.rd = rd;
		o.tag.pc = next_pc;
		next_pc = next_pc + 32'd4;
		e.value = ref_value(fn, a, b);
		e.tag = o.tag;
		e.we = (rd != 5'd0);
		op = o;
		op_valid = 1'b1;
		#1;
		if (refused) begin
			check_ready(op_ready, 1'b0, "op_ready for ALU op in multiply write-back slot");
		end
		waited = 0;
		while (!op_ready) begin
			waited++;
			if (waited > TIMEOUT) begin
				report_error($sformatf("operation at PC %h was never accepted", o.tag.pc));
			end
			@(negedge clk);
			#1;
		end
		exp_res[o.tag.pc] = e;
		exp_cycle[o.tag.pc] = cycle + 1 + ((fn == exe_pkg::OP_MUL) ? MUL_LAT : ALU_LAT);
		@(negedge clk);
		op_valid = 1'b0;
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (exp_res.num() != 0) begin
			@(posedge clk);
			waited++;
			if (waited > TIMEOUT) begin
				report_error($sformatf("%0d results still missing after timeout", exp_res.num()));
			end
		end
		@(negedge clk);
	endtask

	task automatic test_reset();
		#1;
		check_ready(op_ready, 1'b1, "op_ready after reset");
		check_ready(result_valid, 1'b0, "result_valid after reset");
		@(negedge clk);
	endtask

	task automatic test_alu();
		for (int i = 0; i < 16; i++) begin
			issue_op(exe_pkg::exe_op_e'(4'(i % 8)), rand_bits(32), rand_bits(32),
				5'(rand_bits(5)), 1'b0);
		end
		wait_drain();
	endtask

	task automatic test_mul();
		issue_op(exe_pkg::OP_MUL, rand_bits(32), rand_bits(32), 5'd9, 1'b0);
		issue_op(exe_pkg::OP_MUL, rand_bits(32), 32'd0, 5'd10, 1'b0);
		issue_op(exe_pkg::OP_MUL, 32'hffff_ffff, 32'hffff_ffff, 5'd11, 1'b0);
		if (exp_res.num() < 3) begin
			report_error("back-to-back multiplies were not in flight together");
		end
		issue_op(exe_pkg::OP_MUL, 32'd0, rand_bits(32), 5'd12, 1'b0);
		issue_op(exe_pkg::OP_MUL, 32'hffff_ffff, rand_bits(32), 5'd13, 1'b0);
		repeat (4) issue_op(exe_pkg::OP_MUL, rand_bits(32), rand_bits(32), 5'(rand_bits(5)), 1'b0);
		wait_drain();
	endtask

	task automatic test_rd_zero();
		issue_op(exe_pkg::OP_ADD, rand_bits(32), rand_bits(32), 5'd0, 1'b0);
		issue_op(exe_pkg::OP_MUL, rand_bits(32), rand_bits(32), 5'd0, 1'b0);
		wait_drain();
	endtask

	task automatic test_credits();
		@(posedge clk);
		hold_credits = 1'b1;
		@(negedge clk);
		repeat (exe_pkg::DEF_CREDITS) begin
			issue_op(exe_pkg::OP_SUB, rand_bits(32), rand_bits(32), 5'd3, 1'b0);
		end
		wait_drain();
		// This PC is never accepted so any result for it fails in the monitor
		op.op = exe_pkg::OP_ADD;
		op.tag.pc = next_pc;
		next_pc = next_pc + 32'd4;
		op_valid = 1'b1;
		repeat (6) begin
			#1;
			check_ready(op_ready, 1'b0, "op_ready with no credits left");
			@(negedge clk);
		end
		op_valid = 1'b0;
		@(posedge clk);
		hold_credits = 1'b0;
		@(negedge clk);
		repeat (3) issue_op(exe_pkg::OP_OR, rand_bits(32), rand_bits(32), 5'd4, 1'b0);
		wait_drain();
	endtask

	task automatic test_clash();
		issue_op(exe_pkg::OP_MUL, rand_bits(32), rand_bits(32), 5'd7, 1'b0);
		repeat (exe_pkg::DEF_MUL_STAGES - 2) @(negedge clk);
		issue_op(exe_pkg::OP_XOR, rand_bits(32), rand_bits(32), 5'd8, 1'b1);
		wait_drain();
	endtask

	initial begin
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		test_reset();
		test_alu();
		test_mul();
		test_rd_zero();
		test_credits();
		test_clash();
		if (!failed) begin
			$display("TEST OK");
			$finish;
		end else begin
			$display("TEST FAILED");
			$fatal(1, "errors recorded");
		end
	end

endmodule

//--- exe_backend.f
design/exe_pkg.sv
design/int_issue.sv
design/int_alu.sv
design/mul_stage.sv
design/exe_writeback.sv
design/exe_backend.sv
dv/exe_backend_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the exe_backend testbench with Verilator, runs it and looks for the pass line
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f exe_backend.f \
	--top-module exe_backend_tb -Mdir obj_dir -o sim_exe_backend
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_exe_backend 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "TEST OK"; then
	exit 0
fi
echo "Pass line not found in simulation output"
exit 1
